// File: source/offload_pkg.sv
// ----------------------------------------------------------
// Offload complex shared widths, opcode and unit enums,
// bundle widths and path-cut selection
// ----------------------------------------------------------
`default_nettype none

package offload_pkg;

  // ----------------------------------------------------------
  // Datapath widths
  // ----------------------------------------------------------
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ID_WIDTH   = 5;
  localparam int unsigned OP_WIDTH   = 3;

  // Integer operations, encoding 7 left undefined
  typedef enum logic [OP_WIDTH-1:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_MUL  = 3'd2,
    OP_AND  = 3'd3,
    OP_OR   = 3'd4,
    OP_XOR  = 3'd5,
    OP_SLTU = 3'd6
  } offload_op_e;

  // Target unit of a request
  typedef enum logic {
    UNIT_INT    = 1'b0,
    UNIT_SHARED = 1'b1
  } unit_sel_e;

  // ----------------------------------------------------------
  // Packed bundles
  // ----------------------------------------------------------
  // Request is {unit, id, op, arga, argb}
  localparam int unsigned REQ_WIDTH  = 1 + ID_WIDTH + OP_WIDTH + 2 * DATA_WIDTH;
  // Response is {id, data, error}
  localparam int unsigned RESP_WIDTH = ID_WIDTH + DATA_WIDTH + 1;

  // Store (1) or pass through (0) on each path
  localparam bit CUT_OFFLOAD_REQ  = 1'b1;
  localparam bit CUT_OFFLOAD_RESP = 1'b1;

endpackage

`default_nettype wire

// File: source/spill_register.sv
// ----------------------------------------------------------
// Two-entry valid/ready register cutting valid, ready and data
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spill_register #(
  parameter int unsigned WIDTH  = 8,
  parameter bit          BYPASS = 1'b0
) (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             valid_i,
  output logic                  ready_o,
  input  wire logic [WIDTH-1:0] data_i,
  output logic                  valid_o,
  input  wire logic             ready_i,
  output logic      [WIDTH-1:0] data_o
);

  if (BYPASS) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_store
    logic             a_full_q;
    logic [WIDTH-1:0] a_data_q;
    logic             b_full_q;
    logic [WIDTH-1:0] b_data_q;
    logic             a_fill;
    logic             a_drain;
    logic             b_fill;
    logic             b_drain;

    // Main slot takes input, empties whenever spill slot is free
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    // Spill slot catches main slot when output stalls
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        a_full_q <= a_fill || (a_full_q && !a_drain);
        b_full_q <= b_fill || (b_full_q && !b_drain);
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Spill slot holds the older item
    assign valid_o = a_full_q || b_full_q;
    assign ready_o = !a_full_q || !b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    // Offered item must not change while output is stalled
    assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> valid_o && $stable(data_o));
  end

endmodule

`default_nettype wire

// File: source/offload_router.sv
// ----------------------------------------------------------
// Request demultiplexer by unit and round-robin response
// arbiter with grant lock under back-pressure
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module offload_router (
  input  wire logic                                clk_i,
  input  wire logic                                rst_i,
  // Incoming request handshake
  input  wire logic                                req_valid_i,
  output logic                                     req_ready_o,
  input  wire offload_pkg::unit_sel_e              req_unit_i,
  // Unit request handshakes
  output logic                                     int_req_valid_o,
  input  wire logic                                int_req_ready_i,
  output logic                                     shr_req_valid_o,
  input  wire logic                                shr_req_ready_i,
  // Unit responses
  input  wire logic                                int_resp_valid_i,
  output logic                                     int_resp_ready_o,
  input  wire logic [offload_pkg::RESP_WIDTH-1:0]  int_resp_i,
  input  wire logic                                shr_resp_valid_i,
  output logic                                     shr_resp_ready_o,
  input  wire logic [offload_pkg::RESP_WIDTH-1:0]  shr_resp_i,
  // Merged response
  output logic                                     resp_valid_o,
  input  wire logic                                resp_ready_i,
  output logic      [offload_pkg::RESP_WIDTH-1:0]  resp_o
);

  import offload_pkg::*;

  unit_sel_e prio_q;
  unit_sel_e lock_sel_q;
  logic      lock_q;
  unit_sel_e sel;
  logic      resp_xfer;

  // ----------------------------------------------------------
  // Request steering
  // ----------------------------------------------------------
  assign int_req_valid_o = req_valid_i && (req_unit_i == UNIT_INT);
  assign shr_req_valid_o = req_valid_i && (req_unit_i == UNIT_SHARED);
  assign req_ready_o     = (req_unit_i == UNIT_INT) ? int_req_ready_i : shr_req_ready_i;

  // ----------------------------------------------------------
  // Response arbitration
  // ----------------------------------------------------------
  always_comb begin
    if (lock_q) begin
      sel = lock_sel_q;
    end else if (int_resp_valid_i && shr_resp_valid_i) begin
      sel = prio_q;
    end else if (shr_resp_valid_i) begin
      sel = UNIT_SHARED;
    end else begin
      sel = UNIT_INT;
    end
  end

  assign resp_valid_o     = (sel == UNIT_SHARED) ? shr_resp_valid_i : int_resp_valid_i;
  assign resp_o           = (sel == UNIT_SHARED) ? shr_resp_i : int_resp_i;
  assign int_resp_ready_o = resp_ready_i && (sel == UNIT_INT);
  assign shr_resp_ready_o = resp_ready_i && (sel == UNIT_SHARED);
  assign resp_xfer        = resp_valid_o && resp_ready_i;

  // Priority moves past the winner, grant is frozen while stalled
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      prio_q     <= UNIT_INT;
      lock_q     <= 1'b0;
      lock_sel_q <= UNIT_INT;
    end else if (resp_xfer) begin
      prio_q <= (sel == UNIT_INT) ? UNIT_SHARED : UNIT_INT;
      lock_q <= 1'b0;
    end else if (resp_valid_o) begin
      lock_q     <= 1'b1;
      lock_sel_q <= sel;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    !(int_req_valid_o && shr_req_valid_o));

  // Relies on both units holding their offered responses
  assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

`default_nettype wire

// File: source/int_offload_unit.sv
// ----------------------------------------------------------
// Two-stage pipelined integer unit for offloaded operations
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module int_offload_unit (
  input  wire logic                                clk_i,
  input  wire logic                                rst_i,
  input  wire logic                                req_valid_i,
  output logic                                     req_ready_o,
  input  wire logic [offload_pkg::ID_WIDTH-1:0]    req_id_i,
  input  wire offload_pkg::offload_op_e            req_op_i,
  input  wire logic [offload_pkg::DATA_WIDTH-1:0]  req_arga_i,
  input  wire logic [offload_pkg::DATA_WIDTH-1:0]  req_argb_i,
  output logic                                     resp_valid_o,
  input  wire logic                                resp_ready_i,
  output logic      [offload_pkg::RESP_WIDTH-1:0]  resp_o
);

  import offload_pkg::*;

  // Stage 1 operands
  logic                  s1_valid_q;
  logic [ID_WIDTH-1:0]   s1_id_q;
  offload_op_e           s1_op_q;
  logic [DATA_WIDTH-1:0] s1_arga_q;
  logic [DATA_WIDTH-1:0] s1_argb_q;
  // Stage 2 result
  logic                  s2_valid_q;
  logic [ID_WIDTH-1:0]   s2_id_q;
  logic [DATA_WIDTH-1:0] s2_data_q;
  logic                  s2_error_q;

  logic                  s1_free;
  logic                  s2_free;
  logic [DATA_WIDTH-1:0] result;
  logic                  error;

  // Stall chain from the output backwards
  assign s2_free     = !s2_valid_q || resp_ready_i;
  assign s1_free     = !s1_valid_q || s2_free;
  assign req_ready_o = s1_free;

  // ----------------------------------------------------------
  // Execute, includes the multiplier
  // ----------------------------------------------------------
  always_comb begin
    error = 1'b0;
    case (s1_op_q)
      OP_ADD:  result = s1_arga_q + s1_argb_q;
      OP_SUB:  result = s1_arga_q - s1_argb_q;
      OP_MUL:  result = s1_arga_q * s1_argb_q;
      OP_AND:  result = s1_arga_q & s1_argb_q;
      OP_OR:   result = s1_arga_q | s1_argb_q;
      OP_XOR:  result = s1_arga_q ^ s1_argb_q;
      OP_SLTU: result = {{(DATA_WIDTH-1){1'b0}}, (s1_arga_q < s1_argb_q)};
      default: begin
        result = '0;
        error  = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_free) begin
        s1_valid_q <= req_valid_i;
      end
      if (s2_free) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_free && req_valid_i) begin
      s1_id_q   <= req_id_i;
      s1_op_q   <= req_op_i;
      s1_arga_q <= req_arga_i;
      s1_argb_q <= req_argb_i;
    end
    if (s2_free && s1_valid_q) begin
      s2_id_q    <= s1_id_q;
      s2_data_q  <= result;
      s2_error_q <= error;
    end
  end

  assign resp_valid_o = s2_valid_q;
  assign resp_o       = {s2_id_q, s2_data_q, s2_error_q};

endmodule

`default_nettype wire

// File: source/offload_complex.sv
// ----------------------------------------------------------
// Offload complex top with request and response cuts,
// unit router and local integer unit
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module offload_complex (
  input  wire logic                                clk_i,
  input  wire logic                                rst_i,
  // Core-side request
  input  wire logic                                req_valid_i,
  output logic                                     req_ready_o,
  input  wire offload_pkg::unit_sel_e              req_unit_i,
  input  wire logic [offload_pkg::ID_WIDTH-1:0]    req_id_i,
  input  wire offload_pkg::offload_op_e            req_op_i,
  input  wire logic [offload_pkg::DATA_WIDTH-1:0]  req_arga_i,
  input  wire logic [offload_pkg::DATA_WIDTH-1:0]  req_argb_i,
  // Shared-unit request
  output logic                                     shr_req_valid_o,
  input  wire logic                                shr_req_ready_i,
  output logic      [offload_pkg::ID_WIDTH-1:0]    shr_req_id_o,
  output offload_pkg::offload_op_e                 shr_req_op_o,
  output logic      [offload_pkg::DATA_WIDTH-1:0]  shr_req_arga_o,
  output logic      [offload_pkg::DATA_WIDTH-1:0]  shr_req_argb_o,
  // Shared-unit response
  input  wire logic                                shr_resp_valid_i,
  output logic                                     shr_resp_ready_o,
  input  wire logic [offload_pkg::ID_WIDTH-1:0]    shr_resp_id_i,
  input  wire logic [offload_pkg::DATA_WIDTH-1:0]  shr_resp_data_i,
  input  wire logic                                shr_resp_error_i,
  // Core-side response
  output logic                                     resp_valid_o,
  input  wire logic                                resp_ready_i,
  output logic      [offload_pkg::ID_WIDTH-1:0]    resp_id_o,
  output logic      [offload_pkg::DATA_WIDTH-1:0]  resp_data_o,
  output logic                                     resp_error_o
);

  import offload_pkg::*;

  logic [REQ_WIDTH-1:0]  req_bundle_q;
  logic                  req_valid_q;
  logic                  req_ready_q;
  logic                  req_unit_q;
  logic [ID_WIDTH-1:0]   req_id_q;
  logic [OP_WIDTH-1:0]   req_op_q;
  logic [DATA_WIDTH-1:0] req_arga_q;
  logic [DATA_WIDTH-1:0] req_argb_q;

  logic                  int_req_valid;
  logic                  int_req_ready;
  logic                  int_resp_valid;
  logic                  int_resp_ready;
  logic [RESP_WIDTH-1:0] int_resp;
  logic [RESP_WIDTH-1:0] arb_resp;
  logic                  arb_resp_valid;
  logic                  arb_resp_ready;
  logic [RESP_WIDTH-1:0] resp_bundle_q;

  // ----------------------------------------------------------
  // Request path
  // ----------------------------------------------------------
  spill_register #(
    .WIDTH  (REQ_WIDTH),
    .BYPASS (!CUT_OFFLOAD_REQ)
  ) u_req_cut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  ({req_unit_i, req_id_i, req_op_i, req_arga_i, req_argb_i}),
    .valid_o (req_valid_q),
    .ready_i (req_ready_q),
    .data_o  (req_bundle_q)
  );

  assign {req_unit_q, req_id_q, req_op_q, req_arga_q, req_argb_q} = req_bundle_q;

  // Shared port sees the cut request unchanged
  assign shr_req_id_o   = req_id_q;
  assign shr_req_op_o   = offload_op_e'(req_op_q);
  assign shr_req_arga_o = req_arga_q;
  assign shr_req_argb_o = req_argb_q;

  offload_router u_router (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_valid_i      (req_valid_q),
    .req_ready_o      (req_ready_q),
    .req_unit_i       (unit_sel_e'(req_unit_q)),
    .int_req_valid_o  (int_req_valid),
    .int_req_ready_i  (int_req_ready),
    .shr_req_valid_o  (shr_req_valid_o),
    .shr_req_ready_i  (shr_req_ready_i),
    .int_resp_valid_i (int_resp_valid),
    .int_resp_ready_o (int_resp_ready),
    .int_resp_i       (int_resp),
    .shr_resp_valid_i (shr_resp_valid_i),
    .shr_resp_ready_o (shr_resp_ready_o),
    .shr_resp_i       ({shr_resp_id_i, shr_resp_data_i, shr_resp_error_i}),
    .resp_valid_o     (arb_resp_valid),
    .resp_ready_i     (arb_resp_ready),
    .resp_o           (arb_resp)
  );

  int_offload_unit u_int_unit (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (int_req_valid),
    .req_ready_o  (int_req_ready),
    .req_id_i     (req_id_q),
    .req_op_i     (offload_op_e'(req_op_q)),
    .req_arga_i   (req_arga_q),
    .req_argb_i   (req_argb_q),
    .resp_valid_o (int_resp_valid),
    .resp_ready_i (int_resp_ready),
    .resp_o       (int_resp)
  );

  // ----------------------------------------------------------
  // Response path
  // ----------------------------------------------------------
  spill_register #(
    .WIDTH  (RESP_WIDTH),
    .BYPASS (!CUT_OFFLOAD_RESP)
  ) u_resp_cut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (arb_resp_valid),
    .ready_o (arb_resp_ready),
    .data_i  (arb_resp),
    .valid_o (resp_valid_o),
    .ready_i (resp_ready_i),
    .data_o  (resp_bundle_q)
  );

  assign {resp_id_o, resp_data_o, resp_error_o} = resp_bundle_q;

endmodule

`default_nettype wire

// File: sim/tb_offload_complex.sv
// ----------------------------------------------------------
// Offload complex testbench with random traffic, shared-unit
// responder model, reference queues and stall checks
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_offload_complex;

  import offload_pkg::*;

  localparam int unsigned NUM_REQS      = 300;
  localparam int unsigned MAX_CYCLES    = NUM_REQS * 20;
  localparam int unsigned STALL_AT      = 150;
  localparam int unsigned STALL_LEN     = 40;
  localparam int unsigned SHR_REQ_WIDTH = ID_WIDTH + OP_WIDTH + 2 * DATA_WIDTH;

  logic                  clk_i            = 1'b0;
  logic                  rst_i            = 1'b1;
  logic                  req_valid_i      = 1'b0;
  logic                  req_ready_o;
  unit_sel_e             req_unit_i       = UNIT_INT;
  logic [ID_WIDTH-1:0]   req_id_i         = '0;
  offload_op_e           req_op_i         = OP_ADD;
  logic [DATA_WIDTH-1:0] req_arga_i       = '0;
  logic [DATA_WIDTH-1:0] req_argb_i       = '0;
  logic                  shr_req_valid_o;
  logic                  shr_req_ready_i  = 1'b0;
  logic [ID_WIDTH-1:0]   shr_req_id_o;
  offload_op_e           shr_req_op_o;
  logic [DATA_WIDTH-1:0] shr_req_arga_o;
  logic [DATA_WIDTH-1:0] shr_req_argb_o;
  logic                  shr_resp_valid_i = 1'b0;
  logic                  shr_resp_ready_o;
  logic [ID_WIDTH-1:0]   shr_resp_id_i    = '0;
  logic [DATA_WIDTH-1:0] shr_resp_data_i  = '0;
  logic                  shr_resp_error_i = 1'b0;
  logic                  resp_valid_o;
  logic                  resp_ready_i     = 1'b0;
  logic [ID_WIDTH-1:0]   resp_id_o;
  logic [DATA_WIDTH-1:0] resp_data_o;
  logic                  resp_error_o;

  // Traffic process state
  integer                seed          = 41491;
  integer                errors        = 0;
  integer                checks        = 0;
  integer                sent          = 0;
  integer                received      = 0;
  integer                undef_seen    = 0;
  logic                  ready_dropped = 1'b0;
  logic                  hold_pending  = 1'b0;
  logic [ID_WIDTH-1:0]   held_id       = '0;
  logic [DATA_WIDTH-1:0] held_data     = '0;
  logic [2:0]            shr_delay     = 3'd0;
  // Control process state
  logic                  run           = 1'b0;
  logic                  stall_on      = 1'b0;
  integer                main_errors   = 0;
  integer                main_checks   = 0;
  integer                cycles        = 0;

  // Expected responses per unit, shared requests, shared responses to send
  logic [RESP_WIDTH-1:0]    int_q[$];
  logic [RESP_WIDTH-1:0]    shr_q[$];
  logic [RESP_WIDTH-1:0]    shr_pend[$];
  logic [SHR_REQ_WIDTH-1:0] shr_req_q[$];

  offload_complex u_dut (.*);

  always #10 clk_i = ~clk_i;

  // Integer-unit response from the opcode rules
  function automatic logic [RESP_WIDTH-1:0] expected_int_resp(
    input logic [ID_WIDTH-1:0]   id,
    input logic [OP_WIDTH-1:0]   op,
    input logic [DATA_WIDTH-1:0] a,
    input logic [DATA_WIDTH-1:0] b
  );
    logic [DATA_WIDTH-1:0] d;
    logic                  e;
    e = 1'b0;
    case (op)
      OP_ADD:  d = a + b;
      OP_SUB:  d = a - b;
      OP_MUL:  d = a * b;
      OP_AND:  d = a & b;
      OP_OR:   d = a | b;
      OP_XOR:  d = a ^ b;
      OP_SLTU: d = (a < b) ? 32'd1 : 32'd0;
      default: begin
        d = '0;
        e = 1'b1;
      end
    endcase
    return {id, d, e};
  endfunction

  // Reports a mismatch and returns 0
  function automatic bit value_matches(input string name, input logic [71:0] got,
                                       input logic [71:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // ----------------------------------------------------------
  // Request driver, shared-unit model and response checker
  // ----------------------------------------------------------
  always @(posedge clk_i) begin : traffic
    logic [31:0]              rnd;
    logic [RESP_WIDTH-1:0]    got;
    logic [RESP_WIDTH-1:0]    int_head;
    logic [RESP_WIDTH-1:0]    shr_head;
    logic [RESP_WIDTH-1:0]    shr_resp;
    logic [SHR_REQ_WIDTH-1:0] req_head;
    if (!rst_i) begin
      rnd = $random(seed);

      if (req_valid_i && req_ready_o) begin
        sent = sent + 1;
        if (req_unit_i == UNIT_INT) begin
          int_q.push_back(expected_int_resp(req_id_i, req_op_i, req_arga_i, req_argb_i));
        end else begin
          shr_req_q.push_back({req_id_i, req_op_i, req_arga_i, req_argb_i});
          shr_q.push_back({req_id_i, req_arga_i ^ req_argb_i, 1'b0});
        end
      end
      if (!req_valid_i || req_ready_o) begin
        if (run && sent < NUM_REQS && rnd[2:0] != 3'd0) begin
          req_valid_i <= 1'b1;
          req_unit_i  <= unit_sel_e'(rnd[3]);
          req_id_i    <= rnd[8:4];
          req_op_i    <= offload_op_e'(rnd[11:9]);
          req_arga_i  <= $random(seed);
          req_argb_i  <= $random(seed);
        end else begin
          req_valid_i <= 1'b0;
        end
      end

      // Shared unit answers in order with arga ^ argb
      shr_req_ready_i <= (rnd[13:12] != 2'b00);
      if (shr_req_valid_o && shr_req_ready_i) begin
        checks = checks + 1;
        if (shr_req_q.size() == 0) begin
          errors = errors + 1;
          $display("%0t: shared request seen with no shared request outstanding", $time);
        end else begin
          req_head = shr_req_q.pop_front();
          if (!value_matches("shr_req_{id,op,arga,argb}_o",
                             {shr_req_id_o, shr_req_op_o, shr_req_arga_o, shr_req_argb_o},
                             req_head)) begin
            errors = errors + 1;
          end
        end
        shr_resp = {shr_req_id_o, shr_req_arga_o ^ shr_req_argb_o, 1'b0};
        shr_pend.push_back(shr_resp);
      end
      if (shr_resp_valid_i && shr_resp_ready_o) begin
        shr_pend.delete(0);
        shr_resp_valid_i <= 1'b0;
        shr_delay = rnd[17:15];
      end else if (!shr_resp_valid_i && shr_pend.size() != 0) begin
        if (shr_delay == 3'd0) begin
          shr_resp_valid_i <= 1'b1;
          {shr_resp_id_i, shr_resp_data_i, shr_resp_error_i} <= shr_pend[0];
        end else begin
          shr_delay = shr_delay - 3'd1;
        end
      end

      // Core-side responses against the head of either queue
      resp_ready_i <= !stall_on && (rnd[19:18] != 2'b00);
      if (resp_valid_o && resp_ready_i) begin
        got      = {resp_id_o, resp_data_o, resp_error_o};
        int_head = (int_q.size() != 0) ? int_q[0] : '0;
        shr_head = (shr_q.size() != 0) ? shr_q[0] : '0;
        received = received + 1;
        checks   = checks + 1;
        if (int_q.size() != 0 && got == int_head) begin
          int_q.delete(0);
          if (got[0]) begin
            undef_seen = undef_seen + 1;
          end
        end else if (shr_q.size() != 0 && got == shr_head) begin
          shr_q.delete(0);
        end else begin
          errors = errors + 1;
          $display("[FAIL] %0t resp_{id,data,error}_o: got %h, expected %h (int) or %h (shared)",
                   $time, got, int_head, shr_head);
        end
      end

      // Offered response holds while stalled
      if (hold_pending) begin
        checks = checks + 1;
        if (!value_matches("resp_valid_o", 72'(resp_valid_o), 72'd1) ||
            !value_matches("resp_id_o", 72'(resp_id_o), 72'(held_id)) ||
            !value_matches("resp_data_o", 72'(resp_data_o), 72'(held_data))) begin
          errors = errors + 1;
        end
      end
      hold_pending = resp_valid_o && !resp_ready_i;
      held_id      = resp_id_o;
      held_data    = resp_data_o;
      if (stall_on && !req_ready_o) begin
        ready_dropped = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin : main
    integer base;
    integer reset_err;
    integer stall_err;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    base        = main_errors;
    main_checks = main_checks + 2;
    if (!value_matches("resp_valid_o", 72'(resp_valid_o), 72'd0)) begin
      main_errors = main_errors + 1;
    end
    if (!value_matches("shr_req_valid_o", 72'(shr_req_valid_o), 72'd0)) begin
      main_errors = main_errors + 1;
    end
    reset_err = main_errors - base;
    $display("Test reset_state: %0d errors", reset_err);

    run <= 1'b1;
    while (sent < STALL_AT) @(posedge clk_i);
    base = errors + main_errors;
    stall_on <= 1'b1;
    repeat (STALL_LEN) @(posedge clk_i);
    stall_on <= 1'b0;
    @(posedge clk_i);
    main_checks = main_checks + 1;
    if (!ready_dropped) begin
      main_errors = main_errors + 1;
      $display("%0t: req_ready_o never dropped while responses were held back", $time);
    end
    stall_err = errors + main_errors - base;
    $display("Test stall_hold: %0d errors", stall_err);

    while (received < NUM_REQS) @(posedge clk_i);
    repeat (20) @(posedge clk_i);
    main_checks = main_checks + 3;
    if (received != sent || sent != NUM_REQS) begin
      main_errors = main_errors + 1;
      $display("Response count %0d does not match request count %0d", received, sent);
    end
    if (int_q.size() != 0 || shr_q.size() != 0) begin
      main_errors = main_errors + 1;
      $display("Responses missing, %0d integer and %0d shared still expected",
               int_q.size(), shr_q.size());
    end
    if (undef_seen == 0) begin
      main_errors = main_errors + 1;
      $display("No error response was seen for opcode 7");
    end
    $display("Test random_traffic: %0d requests, %0d responses, %0d opcode 7 errors, %0d errors",
             sent, received, undef_seen, errors + main_errors - stall_err - reset_err);

    $display("Checks: %0d, errors: %0d", checks + main_checks, errors + main_errors);
    if (errors + main_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized from the request count
  initial begin : watchdog
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles = cycles + 1;
    end
    $display("Run stopped after %0d cycles with %0d of %0d responses received",
             cycles, received, NUM_REQS);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
source/offload_pkg.sv
source/spill_register.sv
source/offload_router.sv
source/int_offload_unit.sv
source/offload_complex.sv
sim/tb_offload_complex.sv

// File: run.sh
#!/bin/sh
# Build and run the offload complex testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_offload_complex -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build error"
  exit 1
fi

out=$(./obj_dir/Vtb_offload_complex)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
